//--- Bender.yml
package:
  name: id_stage

sources:
  - source/mips_isa_pkg.sv
  - source/id_ctrl_pkg.sv
  - source/id_ifs.sv
  - source/id_decoder.sv
  - source/operand_fwd.sv
  - source/id_ex_reg.sv
  - source/id_stage.sv
  - target: simulation
    files:
      - sim/id_stage_props.sv
      - sim/id_stage_tb.sv

//--- id_stage.f
source/mips_isa_pkg.sv
source/id_ctrl_pkg.sv
source/id_ifs.sv
source/id_decoder.sv
source/operand_fwd.sv
source/id_ex_reg.sv
source/id_stage.sv
sim/id_stage_props.sv
sim/id_stage_tb.sv

//--- sim/id_stage_props.sv
`timescale 1ns/1ps
`default_nettype none

module id_stage_props
    import mips_isa_pkg::*;
    import id_ctrl_pkg::*;
(
    input logic      clk,
    input logic      rst_n_i,
    input logic      reg1_read_o,
    input logic      reg2_read_o,
    input aluop_t    ex_aluop_o,
    input alusel_t   ex_alusel_o,
    input word_t     ex_reg1_o,
    input word_t     ex_reg2_o,
    input reg_addr_t ex_wd_o,
    input logic      ex_wreg_o,
    input logic      ex_inst_valid_o
);

    logic bubble;
    int   fail_cnt = 0; // assertion failures seen so far

    assign bubble = ex_aluop_o == ALUOP_NOP && ex_alusel_o == SEL_NOP
                    && ex_reg1_o == '0 && ex_reg2_o == '0 && ex_wd_o == NOP_REG
                    && !ex_wreg_o && !ex_inst_valid_o;

    reset_bubble: assert property (@(posedge clk) !rst_n_i |=> bubble)
        else begin
            $error("ID/EX outputs are not a bubble after a reset edge");
            fail_cnt++;
        end

    write_is_valid: assert property (@(posedge clk) ex_wreg_o |-> ex_inst_valid_o)
        else begin
            $error("register write without a valid instruction");
            fail_cnt++;
        end

    no_read_in_reset: assert property (@(posedge clk) !rst_n_i |-> !reg1_read_o && !reg2_read_o)
        else begin
            $error("register file read enabled during reset");
            fail_cnt++;
        end

endmodule

bind id_stage id_stage_props u_props (.*);

`default_nettype wire

//--- sim/id_stage_tb.sv
`timescale 1ns/1ps
`default_nettype none

module id_stage_tb
    import mips_isa_pkg::*;
    import id_ctrl_pkg::*;
();

    localparam int NUM_TESTS    = 6;
    localparam int EDGE_TIMEOUT = 100;            // polls per clock edge at 1 ns steps
    localparam word_t DA = 32'hA5A5_0F0F;         // register file port 1
    localparam word_t DB = 32'h0123_4567;         // register file port 2
    localparam word_t DE = 32'hEEEE_0001;         // execute result
    localparam word_t DM = 32'h4D4D_0002;         // memory result

    typedef struct packed {
        word_t      inst;
        word_t      rf1;
        word_t      rf2;
        logic       ex_wreg;
        reg_addr_t  ex_wd;
        word_t      ex_wdata;
        logic       mem_wreg;
        reg_addr_t  mem_wd;
        word_t      mem_wdata;
        logic       rd1;
        logic       rd2;
        aluop_t     aluop;
        alusel_t    alusel;
        word_t      op1;
        word_t      op2;
        reg_addr_t  wd;
        logic       wreg;
        logic       valid;
        logic [2:0] test;
    } vector_t;

    logic      clk;
    logic      rst_n_i;
    word_t     inst_i;
    word_t     reg1_data_i;
    word_t     reg2_data_i;
    logic      ex_wreg_i;
    reg_addr_t ex_wd_i;
    word_t     ex_wdata_i;
    logic      mem_wreg_i;
    reg_addr_t mem_wd_i;
    word_t     mem_wdata_i;
    logic      reg1_read_o;
    logic      reg2_read_o;
    reg_addr_t reg1_addr_o;
    reg_addr_t reg2_addr_o;
    aluop_t    ex_aluop_o;
    alusel_t   ex_alusel_o;
    word_t     ex_reg1_o;
    word_t     ex_reg2_o;
    reg_addr_t ex_wd_o;
    logic      ex_wreg_o;
    logic      ex_inst_valid_o;

    // stimulus for the next table entry
    word_t     pend_rf1;
    word_t     pend_rf2;
    logic      pend_ex_wreg;
    reg_addr_t pend_ex_wd;
    word_t     pend_ex_wdata;
    logic      pend_mem_wreg;
    reg_addr_t pend_mem_wd;
    word_t     pend_mem_wdata;

    vector_t vectors[$];
    int      cur_test;
    int      errors;
    int      test_errs [NUM_TESTS];
    string   test_names [NUM_TESTS];
    string   where;
    integer  seed;

    id_stage i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic word_t rtype(input reg_addr_t rs, input reg_addr_t rt,
                                    input reg_addr_t rd, input shamt_t sa, input funct_t fn);
        return {OP_SPECIAL, rs, rt, rd, sa, fn};
    endfunction

    function automatic word_t itype(input opcode_t op, input reg_addr_t rs,
                                    input reg_addr_t rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // bypass order is execute then memory then register file
    function automatic word_t expected_operand(input logic rd, input reg_addr_t addr,
                                               input word_t rf, input word_t imm);
        if (!rd) return imm;
        if (pend_ex_wreg && pend_ex_wd == addr) return pend_ex_wdata;
        if (pend_mem_wreg && pend_mem_wd == addr) return pend_mem_wdata;
        return rf;
    endfunction

    task automatic clear_pending();
        pend_rf1       = DA;
        pend_rf2       = DB;
        pend_ex_wreg   = 1'b0;
        pend_ex_wd     = '0;
        pend_ex_wdata  = '0;
        pend_mem_wreg  = 1'b0;
        pend_mem_wd    = '0;
        pend_mem_wdata = '0;
    endtask

    task automatic set_forwarding(input logic exw, input reg_addr_t exd, input word_t exdata,
                                  input logic mw, input reg_addr_t md, input word_t mdata);
        pend_ex_wreg   = exw;
        pend_ex_wd     = exd;
        pend_ex_wdata  = exdata;
        pend_mem_wreg  = mw;
        pend_mem_wd    = md;
        pend_mem_wdata = mdata;
    endtask

    task automatic add_vector(input word_t inst, input logic rd1, input logic rd2,
                              input aluop_t aluop, input alusel_t sel, input word_t op1,
                              input word_t op2, input reg_addr_t wd, input logic wreg,
                              input logic valid);
        vector_t v;
        v           = '0;
        v.inst      = inst;
        v.rf1       = pend_rf1;
        v.rf2       = pend_rf2;
        v.ex_wreg   = pend_ex_wreg;
        v.ex_wd     = pend_ex_wd;
        v.ex_wdata  = pend_ex_wdata;
        v.mem_wreg  = pend_mem_wreg;
        v.mem_wd    = pend_mem_wd;
        v.mem_wdata = pend_mem_wdata;
        v.rd1       = rd1;
        v.rd2       = rd2;
        v.aluop     = aluop;
        v.alusel    = sel;
        v.op1       = op1;
        v.op2       = op2;
        v.wd        = wd;
        v.wreg      = wreg;
        v.valid     = valid;
        v.test      = cur_test[2:0];
        vectors.push_back(v);
        clear_pending();
    endtask

    task automatic build_vectors();
        logic [31:0] rnd;
        word_t       r1;
        word_t       r2;
        word_t       imm;
        cur_test = 1;
        add_vector(rtype(1, 2, 3, 0, FN_OR), 1, 1, ALUOP_OR, SEL_LOGIC, DA, DB, 3, 1, 1);
        add_vector(rtype(4, 5, 6, 0, FN_AND), 1, 1, ALUOP_AND, SEL_LOGIC, DA, DB, 6, 1, 1);
        add_vector(rtype(7, 8, 9, 0, FN_XOR), 1, 1, ALUOP_XOR, SEL_LOGIC, DA, DB, 9, 1, 1);
        add_vector(rtype(10, 11, 12, 0, FN_NOR), 1, 1, ALUOP_NOR, SEL_LOGIC, DA, DB, 12, 1, 1);
        add_vector(rtype(13, 14, 15, 0, FN_SLLV), 1, 1, ALUOP_SLL, SEL_SHIFT, DA, DB, 15, 1, 1);
        add_vector(rtype(16, 17, 18, 0, FN_SRLV), 1, 1, ALUOP_SRL, SEL_SHIFT, DA, DB, 18, 1, 1);
        add_vector(rtype(29, 30, 31, 0, FN_SRAV), 1, 1, ALUOP_SRA, SEL_SHIFT, DA, DB, 31, 1, 1);
        cur_test = 2;
        add_vector(itype(OP_ANDI, 4, 5, 16'hF0F0), 1, 0, ALUOP_AND, SEL_LOGIC,
                   DA, 32'h0000_F0F0, 5, 1, 1);
        add_vector(itype(OP_ORI, 4, 6, 16'h8001), 1, 0, ALUOP_OR, SEL_LOGIC,
                   DA, 32'h0000_8001, 6, 1, 1);                // no sign extension
        add_vector(itype(OP_XORI, 7, 8, 16'h1234), 1, 0, ALUOP_XOR, SEL_LOGIC,
                   DA, 32'h0000_1234, 8, 1, 1);
        add_vector(itype(OP_LUI, 0, 9, 16'hBEEF), 1, 0, ALUOP_OR, SEL_LOGIC,
                   DA, 32'hBEEF_0000, 9, 1, 1);
        add_vector(rtype(0, 10, 11, 4, FN_SLL), 0, 1, ALUOP_SLL, SEL_SHIFT, 4, DB, 11, 1, 1);
        add_vector(rtype(0, 12, 13, 31, FN_SRL), 0, 1, ALUOP_SRL, SEL_SHIFT, 31, DB, 13, 1, 1);
        add_vector(rtype(0, 14, 15, 1, FN_SRA), 0, 1, ALUOP_SRA, SEL_SHIFT, 1, DB, 15, 1, 1);
        cur_test = 3;
        set_forwarding(1, 1, DE, 1, 1, DM);                    // both hit rs
        add_vector(rtype(1, 2, 3, 0, FN_OR), 1, 1, ALUOP_OR, SEL_LOGIC, DE, DB, 3, 1, 1);
        set_forwarding(1, 7, DE, 1, 2, DM);
        add_vector(rtype(1, 2, 3, 0, FN_OR), 1, 1, ALUOP_OR, SEL_LOGIC, DA, DM, 3, 1, 1);
        set_forwarding(1, 1, DE, 1, 2, DM);
        add_vector(rtype(1, 2, 3, 0, FN_OR), 1, 1, ALUOP_OR, SEL_LOGIC, DE, DM, 3, 1, 1);
        set_forwarding(0, 1, DE, 0, 2, DM);                    // write enables low
        add_vector(rtype(1, 2, 3, 0, FN_OR), 1, 1, ALUOP_OR, SEL_LOGIC, DA, DB, 3, 1, 1);
        set_forwarding(1, 5, DE, 1, 4, DM);                    // rt hit but port 2 is imm
        add_vector(itype(OP_ORI, 4, 5, 16'h00FF), 1, 0, ALUOP_OR, SEL_LOGIC,
                   DM, 32'h0000_00FF, 5, 1, 1);
        set_forwarding(1, 2, DE, 1, 2, DM);
        add_vector(rtype(0, 2, 3, 7, FN_SLL), 0, 1, ALUOP_SLL, SEL_SHIFT, 7, DE, 3, 1, 1);
        cur_test = 4;
        set_forwarding(1, 1, DE, 1, 2, DM);
        add_vector(itype(6'b111111, 1, 2, 16'h1800), 0, 0, ALUOP_NOP, SEL_NOP, 0, 0, 3, 0, 0);
        add_vector(rtype(1, 2, 3, 5, FN_OR), 0, 0, ALUOP_NOP, SEL_NOP, 0, 0, 3, 0, 0);
        add_vector(rtype(1, 2, 3, 4, FN_SLL), 0, 0, ALUOP_NOP, SEL_NOP, 0, 0, 3, 0, 0);
        add_vector(rtype(1, 2, 3, 0, 6'b101010), 0, 0, ALUOP_NOP, SEL_NOP, 0, 0, 3, 0, 0);
        cur_test = 5;
        for (int i = 0; i < 12; i++) begin
            rnd      = $random(seed);
            r1       = $random(seed);
            r2       = $random(seed);
            pend_rf1 = r1;
            pend_rf2 = r2;
            set_forwarding(rnd[0], rnd[2:1], $random(seed), rnd[3], rnd[5:4], $random(seed));
            imm = {16'h0000, rnd[31:16]};
            case (i % 3)
                0: add_vector(rtype(1, 2, 3, 0, FN_OR), 1, 1, ALUOP_OR, SEL_LOGIC,
                              expected_operand(1, 1, r1, 0), expected_operand(1, 2, r2, 0),
                              3, 1, 1);
                1: add_vector(itype(OP_ORI, 1, 2, rnd[31:16]), 1, 0, ALUOP_OR, SEL_LOGIC,
                              expected_operand(1, 1, r1, imm), imm, 2, 1, 1);
                default: add_vector(rtype(1, 2, 3, 0, FN_SRAV), 1, 1, ALUOP_SRA, SEL_SHIFT,
                                    expected_operand(1, 1, r1, 0),
                                    expected_operand(1, 2, r2, 0), 3, 1, 1);
            endcase
        end
    endtask

    task automatic apply_vector(input vector_t v);
        inst_i      = v.inst;
        reg1_data_i = v.rf1;
        reg2_data_i = v.rf2;
        ex_wreg_i   = v.ex_wreg;
        ex_wd_i     = v.ex_wd;
        ex_wdata_i  = v.ex_wdata;
        mem_wreg_i  = v.mem_wreg;
        mem_wd_i    = v.mem_wd;
        mem_wdata_i = v.mem_wdata;
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            errors++;
            test_errs[cur_test]++;
            $display("error at %0.1f ns: %s %s is %h, expected %h",
                     $realtime, where, what, got, exp);
        end
    endtask

    task automatic check_reads(input vector_t v);
        check_value("reg1_read_o", reg1_read_o, v.rd1);
        check_value("reg2_read_o", reg2_read_o, v.rd2);
        check_value("reg1_addr_o", reg1_addr_o, v.inst[25:21]); // rs
        check_value("reg2_addr_o", reg2_addr_o, v.inst[20:16]); // rt
    endtask

    task automatic check_regs(input vector_t v);
        check_value("ex_aluop_o", ex_aluop_o, v.aluop);
        check_value("ex_alusel_o", ex_alusel_o, v.alusel);
        check_value("ex_reg1_o", ex_reg1_o, v.op1);
        check_value("ex_reg2_o", ex_reg2_o, v.op2);
        check_value("ex_wd_o", ex_wd_o, v.wd);
        check_value("ex_wreg_o", ex_wreg_o, v.wreg);
        check_value("ex_inst_valid_o", ex_inst_valid_o, v.valid);
    endtask

    task automatic check_bubble();
        check_value("ex_aluop_o", ex_aluop_o, ALUOP_NOP);
        check_value("ex_alusel_o", ex_alusel_o, SEL_NOP);
        check_value("ex_reg1_o", ex_reg1_o, 32'h0);
        check_value("ex_reg2_o", ex_reg2_o, 32'h0);
        check_value("ex_wd_o", ex_wd_o, NOP_REG);
        check_value("ex_wreg_o", ex_wreg_o, 1'b0);
        check_value("ex_inst_valid_o", ex_inst_valid_o, 1'b0);
    endtask

    task automatic report_test(input int t);
        if (test_errs[t] == 0) begin
            $display("test %0d %s: ok", t, test_names[t]);
        end else begin
            $display("test %0d %s: %0d errors", t, test_names[t], test_errs[t]);
        end
    endtask

    // polls half a ns off the edge grid and returns 1 ns after the rising edge
    task automatic wait_rise();
        int waited;
        waited = 0;
        #0.5;
        while (clk !== 1'b0 && waited < EDGE_TIMEOUT) begin
            #1;
            waited++;
        end
        while (clk !== 1'b1 && waited < EDGE_TIMEOUT) begin
            #1;
            waited++;
        end
        if (waited >= EDGE_TIMEOUT) begin
            $display("timeout: no rising clock edge within %0d ns", EDGE_TIMEOUT);
            $display("SOME TESTS FAILED");
            $finish;
        end else begin
            #0.5;
        end
    endtask

    initial begin
        int failed;
        seed       = 32'h5646;
        errors     = 0;
        failed     = 0;
        test_errs  = '{default: 0};
        test_names = '{"reset", "r-type logic and shifts", "immediate forms",
                       "forwarding", "invalid encodings", "back-to-back random"};
        rst_n_i     = 1'b0;
        inst_i      = rtype(1, 2, 3, 0, FN_OR); // valid reads masked by reset
        reg1_data_i = DA;
        reg2_data_i = DB;
        ex_wreg_i   = 1'b0;
        ex_wd_i     = '0;
        ex_wdata_i  = '0;
        mem_wreg_i  = 1'b0;
        mem_wd_i    = '0;
        mem_wdata_i = '0;
        clear_pending();
        build_vectors();

        cur_test = 0;
        where    = "in reset";
        repeat (2) wait_rise();
        check_value("reg1_read_o", reg1_read_o, 1'b0);
        check_value("reg2_read_o", reg2_read_o, 1'b0);
        check_value("reg1_addr_o", reg1_addr_o, 32'h0);
        check_value("reg2_addr_o", reg2_addr_o, 32'h0);
        check_bubble();
        repeat (6) wait_rise();
        rst_n_i = 1'b1;
        where   = "after reset";
        check_bubble();                         // no edge since release yet
        report_test(0);

        // entry k goes in while entry k-1 comes out
        for (int k = 0; k <= vectors.size(); k++) begin
            if (k > 0) begin
                cur_test = vectors[k-1].test;
                where    = $sformatf("entry %0d", k - 1);
                check_regs(vectors[k-1]);
                if (k == vectors.size() || vectors[k].test != vectors[k-1].test) begin
                    report_test(cur_test);
                end
            end
            if (k < vectors.size()) begin
                cur_test = vectors[k].test;
                where    = $sformatf("entry %0d", k);
                apply_vector(vectors[k]);
                #18;
                check_reads(vectors[k]);
                wait_rise();
            end
        end

        if (i_dut.u_props.fail_cnt != 0) begin
            $display("%0d concurrent assertion failures in the bound properties",
                     i_dut.u_props.fail_cnt);
            errors += i_dut.u_props.fail_cnt;
        end
        for (int t = 0; t < NUM_TESTS; t++) begin
            if (test_errs[t] != 0) begin
                failed++;
            end
        end
        $display("summary: %0d tests, %0d failed, %0d errors", NUM_TESTS, failed, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- source/id_ctrl_pkg.sv
`default_nettype none

package id_ctrl_pkg;

    typedef logic [7:0] aluop_t;  // operation inside the execute unit
    typedef logic [2:0] alusel_t; // which result the execute stage returns

    localparam aluop_t ALUOP_NOP = 8'b00000000;
    localparam aluop_t ALUOP_OR  = 8'b00100101;
    localparam aluop_t ALUOP_AND = 8'b00100100;
    localparam aluop_t ALUOP_XOR = 8'b00100110;
    localparam aluop_t ALUOP_NOR = 8'b00100111;
    localparam aluop_t ALUOP_SLL = 8'b01111100;
    localparam aluop_t ALUOP_SRL = 8'b00000010;
    localparam aluop_t ALUOP_SRA = 8'b00000011;

    localparam alusel_t SEL_NOP   = 3'b000;
    localparam alusel_t SEL_LOGIC = 3'b001;
    localparam alusel_t SEL_SHIFT = 3'b010;

endpackage

`default_nettype wire

//--- source/id_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module id_decoder
    import mips_isa_pkg::*;
    import id_ctrl_pkg::*;
(
    input  logic  rst_n_i,
    input  word_t inst_i,
    dec_if.ctrl   dec_o
);

    opcode_t           op;
    reg_addr_t         rs;
    reg_addr_t         rt;
    reg_addr_t         rd;
    shamt_t            shamt;
    funct_t            funct;
    logic [HALF_W-1:0] imm16;
    logic              r_hit; // known R-type logic or variable shift

    assign op    = inst_i[31:26];
    assign rs    = inst_i[25:21];
    assign rt    = inst_i[20:16];
    assign rd    = inst_i[15:11];
    assign shamt = inst_i[10:6];
    assign funct = inst_i[5:0];
    assign imm16 = inst_i[15:0];

    always_comb begin
        dec_o.aluop      = ALUOP_NOP;
        dec_o.alusel     = SEL_NOP;
        dec_o.wreg       = 1'b0;
        dec_o.wd         = NOP_REG;
        dec_o.reg1_read  = 1'b0;
        dec_o.reg2_read  = 1'b0;
        dec_o.reg1_addr  = NOP_REG;
        dec_o.reg2_addr  = NOP_REG;
        dec_o.imm        = ZERO_WORD;
        dec_o.inst_valid = 1'b0;
        r_hit            = 1'b0;

        if (rst_n_i) begin
            dec_o.wd        = rd;
            dec_o.reg1_addr = rs;
            dec_o.reg2_addr = rt;

            case (op)
                OP_SPECIAL: begin
                    if (shamt == '0) begin
                        r_hit = 1'b1;
                        case (funct)
                            FN_OR: begin
                                dec_o.aluop  = ALUOP_OR;
                                dec_o.alusel = SEL_LOGIC;
                            end
                            FN_AND: begin
                                dec_o.aluop  = ALUOP_AND;
                                dec_o.alusel = SEL_LOGIC;
                            end
                            FN_XOR: begin
                                dec_o.aluop  = ALUOP_XOR;
                                dec_o.alusel = SEL_LOGIC;
                            end
                            FN_NOR: begin
                                dec_o.aluop  = ALUOP_NOR;
                                dec_o.alusel = SEL_LOGIC;
                            end
                            FN_SLLV: begin
                                dec_o.aluop  = ALUOP_SLL;
                                dec_o.alusel = SEL_SHIFT;
                            end
                            FN_SRLV: begin
                                dec_o.aluop  = ALUOP_SRL;
                                dec_o.alusel = SEL_SHIFT;
                            end
                            FN_SRAV: begin
                                dec_o.aluop  = ALUOP_SRA;
                                dec_o.alusel = SEL_SHIFT;
                            end
                            default: r_hit = 1'b0;
                        endcase
                    end
                    if (r_hit) begin
                        dec_o.wreg       = 1'b1; // writes rd
                        dec_o.reg1_read  = 1'b1;
                        dec_o.reg2_read  = 1'b1;
                        dec_o.inst_valid = 1'b1;
                    end
                end
                OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
                    dec_o.alusel     = SEL_LOGIC;
                    dec_o.wreg       = 1'b1;
                    dec_o.wd         = rt;
                    dec_o.reg1_read  = 1'b1; // rs only, imm replaces port 2
                    dec_o.inst_valid = 1'b1;
                    dec_o.imm        = {{HALF_W{1'b0}}, imm16}; // zero extended
                    case (op)
                        OP_ANDI: dec_o.aluop = ALUOP_AND;
                        OP_XORI: dec_o.aluop = ALUOP_XOR;
                        OP_LUI: begin
                            dec_o.aluop = ALUOP_OR; // rs | (imm << 16)
                            dec_o.imm   = {imm16, {HALF_W{1'b0}}};
                        end
                        default: dec_o.aluop = ALUOP_OR;
                    endcase
                end
                default: ;
            endcase

            // constant shifts, rs field must be zero as well
            if (inst_i[31:21] == '0) begin
                if (funct == FN_SLL || funct == FN_SRL || funct == FN_SRA) begin
                    dec_o.alusel     = SEL_SHIFT;
                    dec_o.wreg       = 1'b1;
                    dec_o.wd         = rd;
                    dec_o.reg1_read  = 1'b0;
                    dec_o.reg2_read  = 1'b1;
                    dec_o.imm        = {{(WORD_W-SHAMT_W){1'b0}}, shamt};
                    dec_o.inst_valid = 1'b1;
                    if (funct == FN_SLL) dec_o.aluop = ALUOP_SLL;
                    else if (funct == FN_SRL) dec_o.aluop = ALUOP_SRL;
                    else dec_o.aluop = ALUOP_SRA;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- source/id_ex_reg.sv
`timescale 1ns/1ps
`default_nettype none

module id_ex_reg
    import mips_isa_pkg::*;
    import id_ctrl_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n_i,
    dec_if.user       dec_i,
    input  word_t     reg1_i,
    input  word_t     reg2_i,
    output aluop_t    ex_aluop_o,
    output alusel_t   ex_alusel_o,
    output word_t     ex_reg1_o,
    output word_t     ex_reg2_o,
    output reg_addr_t ex_wd_o,
    output logic      ex_wreg_o,
    output logic      ex_inst_valid_o
);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            // bubble into execute
            ex_aluop_o      <= ALUOP_NOP;
            ex_alusel_o     <= SEL_NOP;
            ex_reg1_o       <= ZERO_WORD;
            ex_reg2_o       <= ZERO_WORD;
            ex_wd_o         <= NOP_REG;
            ex_wreg_o       <= 1'b0;
            ex_inst_valid_o <= 1'b0;
        end else begin
            ex_aluop_o      <= dec_i.aluop;
            ex_alusel_o     <= dec_i.alusel;
            ex_reg1_o       <= reg1_i;
            ex_reg2_o       <= reg2_i;
            ex_wd_o         <= dec_i.wd;
            ex_wreg_o       <= dec_i.wreg;
            ex_inst_valid_o <= dec_i.inst_valid;
        end
    end

endmodule

`default_nettype wire

//--- source/id_ifs.sv
`timescale 1ns/1ps
`default_nettype none

// bypass results from the execute and memory stages
interface fwd_if import mips_isa_pkg::*; ();
    logic      ex_wreg;  // execute writes a register
    reg_addr_t ex_wd;
    word_t     ex_wdata;
    logic      mem_wreg; // memory stage writes a register
    reg_addr_t mem_wd;
    word_t     mem_wdata;

    modport src  (output ex_wreg, ex_wd, ex_wdata, mem_wreg, mem_wd, mem_wdata);
    modport sink (input  ex_wreg, ex_wd, ex_wdata, mem_wreg, mem_wd, mem_wdata);
endinterface

// decoded control of one instruction
interface dec_if import mips_isa_pkg::*; import id_ctrl_pkg::*; ();
    aluop_t    aluop;
    alusel_t   alusel;
    logic      wreg;       // result goes to wd
    reg_addr_t wd;
    logic      reg1_read;
    logic      reg2_read;
    reg_addr_t reg1_addr;
    reg_addr_t reg2_addr;
    word_t     imm;        // stands in for an unread port
    logic      inst_valid;

    modport ctrl (output aluop, alusel, wreg, wd, reg1_read, reg2_read,
                  reg1_addr, reg2_addr, imm, inst_valid);
    modport user (input  aluop, alusel, wreg, wd, reg1_read, reg2_read,
                  reg1_addr, reg2_addr, imm, inst_valid);
endinterface

`default_nettype wire

//--- source/id_stage.sv
`timescale 1ns/1ps
`default_nettype none

module id_stage
    import mips_isa_pkg::*;
    import id_ctrl_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n_i,
    input  word_t     inst_i,
    input  word_t     reg1_data_i,     // register file port 1
    input  word_t     reg2_data_i,     // register file port 2
    input  logic      ex_wreg_i,
    input  reg_addr_t ex_wd_i,
    input  word_t     ex_wdata_i,
    input  logic      mem_wreg_i,
    input  reg_addr_t mem_wd_i,
    input  word_t     mem_wdata_i,
    output logic      reg1_read_o,
    output logic      reg2_read_o,
    output reg_addr_t reg1_addr_o,
    output reg_addr_t reg2_addr_o,
    output aluop_t    ex_aluop_o,
    output alusel_t   ex_alusel_o,
    output word_t     ex_reg1_o,
    output word_t     ex_reg2_o,
    output reg_addr_t ex_wd_o,
    output logic      ex_wreg_o,
    output logic      ex_inst_valid_o
);

    fwd_if fwd ();
    dec_if dec ();

    word_t reg1;
    word_t reg2;

    assign fwd.ex_wreg   = ex_wreg_i;
    assign fwd.ex_wd     = ex_wd_i;
    assign fwd.ex_wdata  = ex_wdata_i;
    assign fwd.mem_wreg  = mem_wreg_i;
    assign fwd.mem_wd    = mem_wd_i;
    assign fwd.mem_wdata = mem_wdata_i;

    assign reg1_read_o = dec.reg1_read;
    assign reg2_read_o = dec.reg2_read;
    assign reg1_addr_o = dec.reg1_addr;
    assign reg2_addr_o = dec.reg2_addr;

    id_decoder u_dec (
        .rst_n_i (rst_n_i),
        .inst_i  (inst_i),
        .dec_o   (dec)
    );

    operand_fwd u_fwd1 (
        .read_en_i (dec.reg1_read),
        .addr_i    (dec.reg1_addr),
        .rf_data_i (reg1_data_i),
        .imm_i     (dec.imm),
        .fwd_i     (fwd),
        .operand_o (reg1)
    );

    operand_fwd u_fwd2 (
        .read_en_i (dec.reg2_read),
        .addr_i    (dec.reg2_addr),
        .rf_data_i (reg2_data_i),
        .imm_i     (dec.imm),
        .fwd_i     (fwd),
        .operand_o (reg2)
    );

    id_ex_reg u_idex (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .dec_i           (dec),
        .reg1_i          (reg1),
        .reg2_i          (reg2),
        .ex_aluop_o      (ex_aluop_o),
        .ex_alusel_o     (ex_alusel_o),
        .ex_reg1_o       (ex_reg1_o),
        .ex_reg2_o       (ex_reg2_o),
        .ex_wd_o         (ex_wd_o),
        .ex_wreg_o       (ex_wreg_o),
        .ex_inst_valid_o (ex_inst_valid_o)
    );

endmodule

`default_nettype wire

//--- source/mips_isa_pkg.sv
`default_nettype none

package mips_isa_pkg;

    localparam int WORD_W     = 32; // data word and instruction
    localparam int HALF_W     = 16; // immediate field
    localparam int REG_ADDR_W = 5;
    localparam int OPCODE_W   = 6;
    localparam int FUNCT_W    = 6;
    localparam int SHAMT_W    = 5;

    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [OPCODE_W-1:0]   opcode_t;
    typedef logic [FUNCT_W-1:0]    funct_t;
    typedef logic [SHAMT_W-1:0]    shamt_t;

    localparam reg_addr_t NOP_REG   = '0; // $zero
    localparam word_t     ZERO_WORD = '0;

    // primary opcodes
    localparam opcode_t OP_SPECIAL = 6'b000000; // R-type group
    localparam opcode_t OP_ANDI    = 6'b001100;
    localparam opcode_t OP_ORI     = 6'b001101;
    localparam opcode_t OP_XORI    = 6'b001110;
    localparam opcode_t OP_LUI     = 6'b001111;

    // function codes of the SPECIAL group
    localparam funct_t FN_SLL  = 6'b000000; // shift by shamt
    localparam funct_t FN_SRL  = 6'b000010;
    localparam funct_t FN_SRA  = 6'b000011;
    localparam funct_t FN_SLLV = 6'b000100; // shift by rs
    localparam funct_t FN_SRLV = 6'b000110;
    localparam funct_t FN_SRAV = 6'b000111;
    localparam funct_t FN_AND  = 6'b100100;
    localparam funct_t FN_OR   = 6'b100101;
    localparam funct_t FN_XOR  = 6'b100110;
    localparam funct_t FN_NOR  = 6'b100111;

endpackage

`default_nettype wire

//--- source/operand_fwd.sv
`timescale 1ns/1ps
`default_nettype none

module operand_fwd
    import mips_isa_pkg::*;
(
    input  logic      read_en_i,
    input  reg_addr_t addr_i,
    input  word_t     rf_data_i,
    input  word_t     imm_i,
    fwd_if.sink       fwd_i,
    output word_t     operand_o
);

    logic ex_hit;
    logic mem_hit;

    // youngest result wins, $zero is not special here
    assign ex_hit  = fwd_i.ex_wreg && (fwd_i.ex_wd == addr_i);
    assign mem_hit = fwd_i.mem_wreg && (fwd_i.mem_wd == addr_i);

    always_comb begin
        if (!read_en_i) begin
            operand_o = imm_i; // port unused, take immediate
        end else if (ex_hit) begin
            operand_o = fwd_i.ex_wdata;
        end else if (mem_hit) begin
            operand_o = fwd_i.mem_wdata;
        end else begin
            operand_o = rf_data_i;
        end
    end

endmodule

`default_nettype wire
